//--- rtl/nic_rx_pkg.sv
// --------------------
// NIC receive path shared definitions
// Word widths, host register map and the
// ring word layout used by capture and host
// --------------------
package nic_rx_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int MAC_DW = 64;                   // MAC and ring word
    localparam int MAC_KW = 8;                    // One valid bit per byte
    localparam int WB_DW  = 32;                   // Host bus data
    localparam int DROP_W = 16;                   // Dropped frame counter

    // --------------------
    // Host register map
    // --------------------
    // Word addresses inside the register half of the bus space
    localparam int REG_WR_PTR  = 0;               // Committed write pointer (read only)
    localparam int REG_RD_PTR  = 1;               // Committed read pointer
    localparam int REG_DROPPED = 2;               // Dropped frames (read only)

    // --------------------
    // Ring word layout
    // --------------------
    // Descriptor sits in the slot just before the frame data
    typedef struct packed {
        logic [31:0] seq_num;                     // Frame sequence number
        logic [15:0] word_cnt;                    // Data words after descriptor
        logic [15:0] byte_cnt;                    // Valid bytes in frame
    } rx_desc_t;

    // One ring word, seen as data or as descriptor
    typedef union packed {
        logic [MAC_DW-1:0] data;                  // Raw frame word
        rx_desc_t          desc;                  // Descriptor slot
    } rx_word_u;

endpackage

//--- rtl/nic_rx_top.sv
// --------------------
// NIC receive path top level
// Capture, ring buffer and host reader
// around one receive ring
// --------------------
module nic_rx_top #(
    parameter int RX_AW = 10                      // Ring address width
) (
    input  logic                          clk156_25,
    input  logic                          rst_n,
    // MAC receive
    input  logic [nic_rx_pkg::MAC_DW-1:0] mac_rx_data,
    input  logic [nic_rx_pkg::MAC_KW-1:0] mac_rx_data_valid,
    input  logic                          mac_rx_good_frame,
    input  logic                          mac_rx_bad_frame,
    // Wishbone host
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [RX_AW+1:0]              wb_adr,
    input  logic [nic_rx_pkg::WB_DW-1:0]  wb_wdata,
    output logic [nic_rx_pkg::WB_DW-1:0]  wb_rdata,
    output logic                          wb_ack
);

    logic [nic_rx_pkg::DROP_W-1:0] rx_dropped_pkts;  // Capture to host

    rx_ring_if #(.RX_AW(RX_AW)) rx_ring ();

    rx_mac_capture #(.RX_AW(RX_AW)) u_capture (
        .clk156_25     (clk156_25),
        .rst_n         (rst_n),
        .rx_data       (mac_rx_data),
        .rx_data_valid (mac_rx_data_valid),
        .rx_good_frame (mac_rx_good_frame),
        .rx_bad_frame  (mac_rx_bad_frame),
        .ring          (rx_ring.capture),
        .dropped_pkts  (rx_dropped_pkts)
    );

    rx_ring_buffer #(.RX_AW(RX_AW)) u_buffer (
        .clk156_25 (clk156_25),
        .ring      (rx_ring.buffer)
    );

    rx_host_reader #(.RX_AW(RX_AW)) u_host (
        .clk156_25    (clk156_25),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_wdata     (wb_wdata),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack),
        .ring         (rx_ring.host),
        .dropped_pkts (rx_dropped_pkts)
    );

endmodule

//--- rtl/rx_host_reader.sv
// --------------------
// Host reader as a Wishbone classic slave
// Pointer and drop count registers
// Buffer reads in 32-bit halves
// Read pointer write releases ring space
// --------------------
module rx_host_reader #(
    parameter int RX_AW = 10                      // Ring address width
) (
    input  logic                          clk156_25,
    input  logic                          rst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [RX_AW+1:0]              wb_adr,
    input  logic [nic_rx_pkg::WB_DW-1:0]  wb_wdata,
    output logic [nic_rx_pkg::WB_DW-1:0]  wb_rdata,
    output logic                          wb_ack,
    rx_ring_if.host                       ring,
    input  logic [nic_rx_pkg::DROP_W-1:0] dropped_pkts
);

    localparam logic [RX_AW:0] DEPTH = {1'b1, {RX_AW{1'b0}}};  // Ring words

    logic                         req;            // New request seen
    logic                         buf_sel;        // Top address bit
    logic                         rd_pend;        // Waiting on ring data
    logic                         rd_ptr_wr;      // Read pointer update
    logic [RX_AW:0]               new_rd_ptr;
    logic [RX_AW:0]               rd_room;        // Occupancy after update
    logic [nic_rx_pkg::WB_DW-1:0] reg_rdata;

    // --------------------
    // Decode
    // --------------------
    always_comb begin
        req        = wb_cyc && wb_stb && !wb_ack && !rd_pend;  // One in flight
        buf_sel    = wb_adr[RX_AW+1];
        new_rd_ptr = wb_wdata[RX_AW:0];
        rd_room    = ring.committed_wr_addr - new_rd_ptr;
        rd_ptr_wr  = req && wb_we && !buf_sel &&
                     (wb_adr[RX_AW:0] == nic_rx_pkg::REG_RD_PTR);
        ring.rd_addr = {1'b0, wb_adr[RX_AW:1]};   // Held by master until ack
    end

    // Register read mux, zero extended
    always_comb begin
        reg_rdata = '0;
        case (wb_adr[RX_AW:0])
            nic_rx_pkg::REG_WR_PTR:  reg_rdata[RX_AW:0] = ring.committed_wr_addr;
            nic_rx_pkg::REG_RD_PTR:  reg_rdata[RX_AW:0] = ring.committed_rd_addr;
            nic_rx_pkg::REG_DROPPED: reg_rdata[nic_rx_pkg::DROP_W-1:0] = dropped_pkts;
            default: ;                            // Unmapped reads as zero
        endcase
    end

    // --------------------
    // Bus control
    // --------------------
    always_ff @(posedge clk156_25) begin
        if (!rst_n) begin
            wb_ack                 <= 1'b0;
            rd_pend                <= 1'b0;
            ring.committed_rd_addr <= '0;
        end else begin
            wb_ack <= 1'b0;
            if (rd_pend) begin
                rd_pend <= 1'b0;                  // Ring data now valid
                wb_ack  <= 1'b1;
            end else if (req) begin
                if (buf_sel && !wb_we) begin
                    rd_pend <= 1'b1;              // Ack two cycles after stb
                end else begin
                    wb_ack <= 1'b1;               // Registers and ignored writes
                end
            end
            if (rd_ptr_wr) begin
                ring.committed_rd_addr <= new_rd_ptr;
            end
        end
    end

    // Read data
    always_ff @(posedge clk156_25) begin
        if (rd_pend) begin
            wb_rdata <= wb_adr[0] ?
                        ring.rd_data[nic_rx_pkg::MAC_DW-1:nic_rx_pkg::WB_DW] :
                        ring.rd_data[nic_rx_pkg::WB_DW-1:0];
        end else if (req && !buf_sel) begin
            wb_rdata <= reg_rdata;
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_ack_in_cycle: assert property (
        @(posedge clk156_25) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
    );

    // Host may only release space that capture has committed
    a_rd_ptr_bound: assert property (
        @(posedge clk156_25) disable iff (!rst_n) rd_ptr_wr |-> (rd_room <= DEPTH)
    );

endmodule

//--- rtl/rx_mac_capture.sv
// --------------------
// MAC receive capture
// Writes frame words after a reserved descriptor slot
// Good frame writes descriptor and commits
// Bad frame rolls back, frame without room is dropped
// --------------------
module rx_mac_capture #(
    parameter int RX_AW = 10                      // Ring address width
) (
    input  logic                          clk156_25,
    input  logic                          rst_n,
    input  logic [nic_rx_pkg::MAC_DW-1:0] rx_data,
    input  logic [nic_rx_pkg::MAC_KW-1:0] rx_data_valid,
    input  logic                          rx_good_frame,
    input  logic                          rx_bad_frame,
    rx_ring_if.capture                    ring,
    output logic [nic_rx_pkg::DROP_W-1:0] dropped_pkts
);

    localparam logic [RX_AW:0] DEPTH = {1'b1, {RX_AW{1'b0}}};  // Ring words

    logic [RX_AW:0]       start_ptr;              // Descriptor slot of current frame
    logic [15:0]          word_cnt;               // Data words so far
    logic [15:0]          byte_cnt;               // Valid bytes so far
    logic [31:0]          seq_num;                // Next descriptor sequence number
    logic                 ovf;                    // Frame ran out of room
    logic                 data_word;              // MAC word this cycle
    logic [RX_AW:0]       cur_addr;               // Slot for this word
    logic [RX_AW:0]       fill;                   // Used space if word is written
    logic                 word_fits;
    logic [3:0]           word_bytes;             // Popcount of mask
    logic [RX_AW:0]       used;                   // Committed occupancy
    nic_rx_pkg::rx_word_u desc_word;

    // --------------------
    // Room check
    // --------------------
    always_comb begin
        data_word = |rx_data_valid;
        cur_addr  = start_ptr + 1'b1 + word_cnt[RX_AW:0];  // Skip descriptor slot
        fill      = cur_addr - ring.committed_rd_addr;     // Modulo wrap bit
        word_fits = fill < DEPTH;
    end

    always_comb begin
        word_bytes = '0;
        for (int i = 0; i < nic_rx_pkg::MAC_KW; i++) begin
            word_bytes = word_bytes + 4'(rx_data_valid[i]);
        end
    end

    // Descriptor built through the union
    always_comb begin
        desc_word.desc.seq_num  = seq_num;
        desc_word.desc.word_cnt = word_cnt;
        desc_word.desc.byte_cnt = byte_cnt;
    end

    // --------------------
    // Frame control
    // --------------------
    always_ff @(posedge clk156_25) begin
        if (!rst_n) begin
            ring.wr_en             <= 1'b0;
            ring.committed_wr_addr <= '0;
            start_ptr              <= '0;
            word_cnt               <= '0;
            byte_cnt               <= '0;
            ovf                    <= 1'b0;
            seq_num                <= '0;
            dropped_pkts           <= '0;
        end else begin
            ring.wr_en             <= 1'b0;
            ring.committed_wr_addr <= start_ptr;   // Follows descriptor write
            if (rx_good_frame && !ovf) begin
                ring.wr_en <= 1'b1;                 // Descriptor write
                start_ptr  <= start_ptr + 1'b1 + word_cnt[RX_AW:0];
                seq_num    <= seq_num + 1'b1;
            end else if (rx_good_frame) begin
                if (dropped_pkts != '1) begin       // Saturating count
                    dropped_pkts <= dropped_pkts + 1'b1;
                end
            end else if (data_word && !ovf) begin
                if (word_fits) begin
                    ring.wr_en <= 1'b1;
                end else begin
                    ovf <= 1'b1;                    // Sticky until frame end
                end
                word_cnt <= word_cnt + 1'b1;
                byte_cnt <= byte_cnt + 16'(word_bytes);
            end
            if (rx_good_frame || rx_bad_frame) begin
                word_cnt <= '0;                     // Rollback keeps start_ptr
                byte_cnt <= '0;
                ovf      <= 1'b0;
            end
        end
    end

    // Write port payload
    always_ff @(posedge clk156_25) begin
        if (rx_good_frame) begin
            ring.wr_addr <= start_ptr;
            ring.wr_data <= desc_word.data;
        end else begin
            ring.wr_addr <= cur_addr;
            ring.wr_data <= rx_data;
        end
    end

    // --------------------
    // Checks
    // --------------------
    assign used = ring.committed_wr_addr - ring.committed_rd_addr;

    a_used_in_depth: assert property (
        @(posedge clk156_25) disable iff (!rst_n) used <= DEPTH
    );

    a_one_status: assert property (
        @(posedge clk156_25) disable iff (!rst_n) !(rx_good_frame && rx_bad_frame)
    );

endmodule

//--- rtl/rx_ring_buffer.sv
// --------------------
// Receive ring memory
// Simple dual port, registered read port
// --------------------
module rx_ring_buffer #(
    parameter int RX_AW = 10                      // Ring address width
) (
    input  logic      clk156_25,
    rx_ring_if.buffer ring
);

    localparam int DEPTH = 2 ** RX_AW;

    logic [nic_rx_pkg::MAC_DW-1:0] mem [DEPTH];  // Ring storage

    // --------------------
    // Write port
    // --------------------
    // Wrap bit of the pointer does not index memory
    always_ff @(posedge clk156_25) begin
        if (ring.wr_en) begin
            mem[ring.wr_addr[RX_AW-1:0]] <= ring.wr_data;
        end
    end

    // --------------------
    // Read port
    // --------------------
    always_ff @(posedge clk156_25) begin
        ring.rd_data <= mem[ring.rd_addr[RX_AW-1:0]];  // One cycle latency
    end

endmodule

//--- rtl/rx_ring_if.sv
// --------------------
// Receive ring interface
// Joins capture, ring memory and host reader
// Pointers carry one extra wrap bit
// --------------------
interface rx_ring_if #(
    parameter int RX_AW = 10                      // Ring address width
);

    logic                          wr_en;         // Ring write strobe
    logic [RX_AW:0]                wr_addr;       // Write pointer with wrap bit
    logic [nic_rx_pkg::MAC_DW-1:0] wr_data;       // Frame word or descriptor
    logic [RX_AW:0]                rd_addr;       // Host read pointer
    logic [nic_rx_pkg::MAC_DW-1:0] rd_data;       // Registered read data
    logic [RX_AW:0]                committed_wr_addr;  // End of last good frame
    logic [RX_AW:0]                committed_rd_addr;  // Space freed by host

    // Frame capture side
    modport capture (
        output wr_en, wr_addr, wr_data, committed_wr_addr,
        input  committed_rd_addr
    );

    // Ring memory
    modport buffer (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data
    );

    // Host reader side
    modport host (
        output rd_addr, committed_rd_addr,
        input  rd_data, committed_wr_addr
    );

endinterface

//--- run.sh
#!/bin/sh
# Build and run the receive path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_nic_rx -Mdir obj_dir -f verilog.f
out=$(./obj_dir/Vtb_nic_rx)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- test/tb_nic_rx.sv
// --------------------
// NIC receive path testbench
// Random MAC frames against a ring model,
// Wishbone reads, drains and read pointer release
// --------------------
module tb_nic_rx;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RX_AW       = 6;               // Small ring so frames overflow fast
    localparam int PTR_W       = RX_AW + 1;
    localparam int ADR_W       = RX_AW + 2;
    localparam int DEPTH       = 2 ** RX_AW;
    localparam int N_FRAMES    = 80;
    localparam int ACK_TIMEOUT = 16;              // Cycles per bus request

    logic                          clk156_25;
    logic                          rst_n;
    logic [nic_rx_pkg::MAC_DW-1:0] mac_rx_data;
    logic [nic_rx_pkg::MAC_KW-1:0] mac_rx_data_valid;
    logic                          mac_rx_good_frame;
    logic                          mac_rx_bad_frame;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [ADR_W-1:0]              wb_adr;
    logic [nic_rx_pkg::WB_DW-1:0]  wb_wdata;
    logic [nic_rx_pkg::WB_DW-1:0]  wb_rdata;
    logic                          wb_ack;

    // --------------------
    // Ring model
    // --------------------
    logic [31:0]                   rng_state;
    logic [PTR_W-1:0]              exp_wr;        // Committed write pointer
    logic [PTR_W-1:0]              exp_rd;        // Host read pointer
    logic [31:0]                   exp_seq;       // Next accepted frame number
    logic [nic_rx_pkg::DROP_W-1:0] exp_dropped;
    nic_rx_pkg::rx_desc_t          exp_desc_q[$]; // Accepted, not yet drained
    logic [nic_rx_pkg::MAC_DW-1:0] exp_data_q[$];
    logic [nic_rx_pkg::MAC_DW-1:0] frame_q[$];    // Frame being sent
    int ptr_errs = 0;
    int desc_errs = 0;
    int word_errs = 0;
    int count_errs = 0;
    int other_errs = 0;

    nic_rx_top #(.RX_AW(RX_AW)) u_dut (.*);

    initial begin
        clk156_25 = 1'b0;
        forever #4 clk156_25 = ~clk156_25;        // 8 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_ptr(input string name, input logic [PTR_W-1:0] got,
                             input logic [PTR_W-1:0] exp);
        if (got !== exp) begin
            ptr_errs++;
            $display("error %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_desc(input string name, input nic_rx_pkg::rx_desc_t got,
                              input nic_rx_pkg::rx_desc_t exp);
        if (got !== exp) begin
            desc_errs++;
            $display("error %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [nic_rx_pkg::MAC_DW-1:0] got,
                              input logic [nic_rx_pkg::MAC_DW-1:0] exp);
        if (got !== exp) begin
            word_errs++;
            $display("error %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [nic_rx_pkg::DROP_W-1:0] got,
                               input logic [nic_rx_pkg::DROP_W-1:0] exp);
        if (got !== exp) begin
            count_errs++;
            $display("error %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("errors: ptr %0d desc %0d word %0d count %0d other %0d",
                 ptr_errs, desc_errs, word_errs, count_errs, other_errs);
    endtask

    task automatic abort_run(input string why);
        other_errs++;
        $display("%s", why);
        print_counts();
        $display("Test failed");
        $finish;
    endtask

    // --------------------
    // Wishbone host
    // --------------------
    task automatic wb_transfer(input logic we, input logic [ADR_W-1:0] adr,
                               input logic [nic_rx_pkg::WB_DW-1:0] wdata,
                               output logic [nic_rx_pkg::WB_DW-1:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk156_25);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        do begin
            @(negedge clk156_25);
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        if (!wb_ack) begin
            abort_run("Wishbone request was never acknowledged");
        end else begin
            rdata = wb_rdata;
            @(negedge clk156_25);                 // Hold stb over the ack edge
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic read_reg(input int idx, output logic [nic_rx_pkg::WB_DW-1:0] data);
        wb_transfer(1'b0, ADR_W'(idx), '0, data);
    endtask

    task automatic write_reg(input int idx, input logic [nic_rx_pkg::WB_DW-1:0] data);
        logic [nic_rx_pkg::WB_DW-1:0] discard;
        wb_transfer(1'b1, ADR_W'(idx), data, discard);
    endtask

    // Low half at bit 0 clear, high half at bit 0 set
    task automatic read_ring_word(input logic [PTR_W-1:0] ptr,
                                  output logic [nic_rx_pkg::MAC_DW-1:0] word);
        logic [nic_rx_pkg::WB_DW-1:0] lo;
        logic [nic_rx_pkg::WB_DW-1:0] hi;
        wb_transfer(1'b0, {1'b1, ptr[RX_AW-1:0], 1'b0}, '0, lo);
        wb_transfer(1'b0, {1'b1, ptr[RX_AW-1:0], 1'b1}, '0, hi);
        word = {hi, lo};
    endtask

    task automatic check_registers();
        logic [nic_rx_pkg::WB_DW-1:0] r;
        read_reg(nic_rx_pkg::REG_WR_PTR, r);
        check_ptr("wr_ptr", r[PTR_W-1:0], exp_wr);
        read_reg(nic_rx_pkg::REG_RD_PTR, r);
        check_ptr("rd_ptr", r[PTR_W-1:0], exp_rd);
        read_reg(nic_rx_pkg::REG_DROPPED, r);
        check_count("dropped_pkts", r[nic_rx_pkg::DROP_W-1:0], exp_dropped);
    endtask

    // --------------------
    // MAC side and model
    // --------------------
    task automatic send_frame(input int n_words, input int last_bytes, input logic good);
        logic [7:0] last_mask;
        last_mask = 8'((1 << last_bytes) - 1);    // Bytes from byte 0 up
        for (int i = 0; i < n_words; i++) begin
            @(negedge clk156_25);
            if (wb_ack !== 1'b0) begin
                other_errs++;
                $display("error %0t: wb_ack got %b expected 0", $time, wb_ack);
            end
            mac_rx_data       = frame_q[i];
            mac_rx_data_valid = (i == n_words - 1) ? last_mask : 8'hff;
        end
        @(negedge clk156_25);
        mac_rx_data_valid = '0;
        mac_rx_good_frame = good;                 // Status on cycle after last word
        mac_rx_bad_frame  = !good;
        @(negedge clk156_25);
        mac_rx_good_frame = 1'b0;
        mac_rx_bad_frame  = 1'b0;
        @(negedge clk156_25);                     // Idle gap
    endtask

    task automatic model_frame(input int n_words, input int last_bytes, input logic good);
        nic_rx_pkg::rx_desc_t d;
        logic [PTR_W-1:0]     used;
        used = exp_wr - exp_rd;
        if (good && int'(used) + 1 + n_words <= DEPTH) begin
            d.seq_num  = exp_seq;
            d.word_cnt = 16'(n_words);
            d.byte_cnt = 16'(8 * (n_words - 1) + last_bytes);
            exp_desc_q.push_back(d);
            foreach (frame_q[i]) begin
                exp_data_q.push_back(frame_q[i]);
            end
            exp_wr  = exp_wr + PTR_W'(1 + n_words);
            exp_seq = exp_seq + 1;
        end else if (good && exp_dropped != '1) begin
            exp_dropped = exp_dropped + 1'b1;     // No room, frame dropped
        end
    endtask

    // Host reads and releases every waiting frame
    task automatic drain_ring();
        nic_rx_pkg::rx_desc_t          d;
        nic_rx_pkg::rx_word_u          w;
        logic [nic_rx_pkg::MAC_DW-1:0] raw;
        logic [nic_rx_pkg::WB_DW-1:0]  r;
        while (exp_desc_q.size() > 0) begin
            d = exp_desc_q.pop_front();
            read_ring_word(exp_rd, raw);
            w.data = raw;
            check_desc("ring descriptor", w.desc, d);
            for (int i = 0; i < int'(d.word_cnt); i++) begin
                read_ring_word(exp_rd + PTR_W'(1 + i), raw);
                w.data = raw;
                check_word("ring data", w.data, exp_data_q.pop_front());
            end
            exp_rd = exp_rd + PTR_W'(1 + int'(d.word_cnt));
            write_reg(nic_rx_pkg::REG_RD_PTR, 32'(exp_rd));
            read_reg(nic_rx_pkg::REG_RD_PTR, r);
            check_ptr("rd_ptr", r[PTR_W-1:0], exp_rd);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int   n_words;
        int   last_bytes;
        logic good;
        rst_n             = 1'b0;
        mac_rx_data       = '0;
        mac_rx_data_valid = '0;
        mac_rx_good_frame = 1'b0;
        mac_rx_bad_frame  = 1'b0;
        wb_cyc            = 1'b0;
        wb_stb            = 1'b0;
        wb_we             = 1'b0;
        wb_adr            = '0;
        wb_wdata          = '0;
        rng_state         = 32'h9e452dbb;
        exp_wr            = '0;
        exp_rd            = '0;
        exp_seq           = '0;
        exp_dropped       = '0;
        repeat (10) @(posedge clk156_25);
        @(negedge clk156_25);
        rst_n = 1'b1;
        check_registers();                        // All zero after reset
        for (int f = 0; f < N_FRAMES; f++) begin
            n_words    = 1 + int'(next_rand() % 40);
            last_bytes = 1 + int'(next_rand() % 8);
            good       = (next_rand() % 4) != 0;
            frame_q.delete();
            for (int i = 0; i < n_words; i++) begin
                frame_q.push_back({next_rand(), next_rand()});
            end
            send_frame(n_words, last_bytes, good);
            model_frame(n_words, last_bytes, good);
            check_registers();
            if ((next_rand() % 4) == 0) begin     // Host drains now and then
                drain_ring();
            end
        end
        drain_ring();
        print_counts();
        if (ptr_errs + desc_errs + word_errs + count_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/nic_rx_pkg.sv
rtl/rx_ring_if.sv
rtl/rx_mac_capture.sv
rtl/rx_ring_buffer.sv
rtl/rx_host_reader.sv
rtl/nic_rx_top.sv
test/tb_nic_rx.sv
